//--- flist.f
src/cce_pkg.sv
src/cce_req_fifo.sv
src/cce_dir_slice.sv
src/cce_engine.sv
src/cce_cmd_issue.sv
src/cce_top.sv
sim/cce_checker.sv
sim/cce_tb.sv

//--- Bender.yml
package:
  name: cce

sources:
  - src/cce_pkg.sv
  - src/cce_req_fifo.sv
  - src/cce_dir_slice.sv
  - src/cce_engine.sv
  - src/cce_cmd_issue.sv
  - src/cce_top.sv
  - target: simulation
    files:
      - sim/cce_checker.sv
      - sim/cce_tb.sv

//--- sim/cce_tb.sv
// Testbench for the directory engine, checks every command against a reference directory model
module cce_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REQ_LIMIT   = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam int NUM_RAND    = 60;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic              req_ready;
  cce_pkg::lce_req_s req;
  logic              cmd_valid;
  logic              cmd_ready;
  cce_pkg::lce_cmd_s cmd;
  logic              rand_ready;

  // Expected commands in transfer order
  cce_pkg::lce_cmd_s         exp_q [$];
  logic [cce_pkg::TAG_W-1:0] model_tag [cce_pkg::NUM_LCE][cce_pkg::NUM_SETS];
  cce_pkg::coh_state_e       model_state [cce_pkg::NUM_LCE][cce_pkg::NUM_SETS];
  // Two pairs of blocks that collide in the same set
  logic [15:0] rand_addr [4] = '{16'h1000, 16'h2000, 16'h1040, 16'h3040};
  int errors = 0;
  int checks = 0;
  int test_num = 0;
  int test_cmds = 0;
  int done_total = 0;
  int stall_cycles = 0;
  int accepted_total = 0;

  cce_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .cmd_o       (cmd)
  );

  bind cce_top cce_checker cmd_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .req_i       (req_i),
    .cmd_valid_i (cmd_valid_o),
    .cmd_ready_i (cmd_ready_i),
    .cmd_i       (cmd_o)
  );

  always #5 clk = ~clk;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic cce_pkg::lce_req_s build_req(input int lce, input cce_pkg::lce_req_e t,
                                                  input logic [15:0] addr);
    cce_pkg::lce_req_s r;
    r.lce_id   = cce_pkg::LCE_ID_W'(lce);
    r.req_type = t;
    r.addr     = addr;
    return r;
  endfunction

  // Command rule and directory rule applied to the model directory
  function automatic void ref_apply(input cce_pkg::lce_req_s r);
    logic [cce_pkg::SET_W-1:0] set;
    logic [cce_pkg::TAG_W-1:0] tag;
    cce_pkg::coh_state_e       st [cce_pkg::NUM_LCE];
    cce_pkg::coh_state_e       grant;
    cce_pkg::lce_cmd_s         c;
    logic                      others_held;
    set         = r.addr[cce_pkg::BLOCK_OFFSET_W +: cce_pkg::SET_W];
    tag         = r.addr[cce_pkg::ADDR_W-1 -: cce_pkg::TAG_W];
    others_held = 1'b0;
    c.addr      = r.addr;
    for (int i = 0; i < cce_pkg::NUM_LCE; i++) begin
      st[i] = (model_tag[i][set] == tag) ? model_state[i][set] : cce_pkg::e_coh_i;
    end
    for (int i = 0; i < cce_pkg::NUM_LCE; i++) begin
      if (i != int'(r.lce_id) && st[i] != cce_pkg::e_coh_i) begin
        others_held = 1'b1;
        c.dst_id    = cce_pkg::LCE_ID_W'(i);
        if (r.req_type == cce_pkg::e_req_rd_excl) begin
          c.opcode = cce_pkg::e_cmd_inv;
          exp_q.push_back(c);
        end else if (r.req_type == cce_pkg::e_req_rd_shared && st[i] == cce_pkg::e_coh_e) begin
          c.opcode = cce_pkg::e_cmd_downgrade;
          exp_q.push_back(c);
        end
      end
    end
    case (r.req_type)
      cce_pkg::e_req_rd_excl: begin
        grant    = cce_pkg::e_coh_e;
        c.opcode = cce_pkg::e_cmd_grant_e;
      end
      cce_pkg::e_req_rd_shared: begin
        grant    = others_held ? cce_pkg::e_coh_s : cce_pkg::e_coh_e;
        c.opcode = others_held ? cce_pkg::e_cmd_grant_s : cce_pkg::e_cmd_grant_e;
      end
      default: begin
        grant    = cce_pkg::e_coh_i;
        c.opcode = cce_pkg::e_cmd_wb_ack;
      end
    endcase
    c.dst_id = r.lce_id;
    exp_q.push_back(c);
    for (int i = 0; i < cce_pkg::NUM_LCE; i++) begin
      if (i == int'(r.lce_id)) begin
        model_tag[i][set]   = tag;
        model_state[i][set] = grant;
      end else if (st[i] != cce_pkg::e_coh_i) begin
        if (r.req_type == cce_pkg::e_req_rd_excl) begin
          model_state[i][set] = cce_pkg::e_coh_i;
        end else if (r.req_type == cce_pkg::e_req_rd_shared && st[i] == cce_pkg::e_coh_e) begin
          model_state[i][set] = cce_pkg::e_coh_s;
        end
      end
    end
  endfunction

  // Sampled at the falling edge ahead of the rising edge that completes the handshake
  always @(negedge clk) begin
    if (rst_n && req_valid) begin
      if (req_ready) begin
        accepted_total++;
        ref_apply(req);
      end else begin
        stall_cycles++;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && cmd_valid && cmd_ready) begin
      test_cmds++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected command %h at %0t with nothing outstanding", cmd, $time);
      end else begin
        check_value(cmd, exp_q.pop_front(), $sformatf("command %0d", test_cmds));
      end
      // A grant or ack closes one request
      if (cmd.opcode == cce_pkg::e_cmd_grant_s || cmd.opcode == cce_pkg::e_cmd_grant_e ||
          cmd.opcode == cce_pkg::e_cmd_wb_ack) begin
        done_total++;
      end
    end
  end

  // Random back-pressure on the command port
  always begin
    @(posedge clk);
    #1;
    cmd_ready = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
  end

  task automatic send_req(input cce_pkg::lce_req_s r);
    int waited;
    waited    = 0;
    req       = r;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready && waited < REQ_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      errors++;
      $display("timeout: request was never accepted at %0t", $time);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || cmd_valid) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0 || cmd_valid) begin
      errors++;
      $display("timeout: %0d expected commands never arrived", exp_q.size());
    end
  endtask

  task automatic end_test(input string name, input int exp_cmds);
    wait_drain();
    if (exp_cmds >= 0) begin
      check_value(test_cmds, exp_cmds, {name, " command count"});
    end
    test_num++;
    $display("test %0d %s finished with %0d commands, %0d errors so far",
             test_num, name, test_cmds, errors);
    test_cmds = 0;
  endtask

  initial begin
    void'($urandom(32'h9212));
    clk        = 1'b0;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    cmd_ready  = 1'b1;
    rand_ready = 1'b0;
    for (int i = 0; i < cce_pkg::NUM_LCE; i++) begin
      for (int s = 0; s < cce_pkg::NUM_SETS; s++) begin
        model_tag[i][s]   = '0;
        model_state[i][s] = cce_pkg::e_coh_i;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value(req_ready, 1'b1, "request ready after reset");
    check_value(cmd_valid, 1'b0, "command valid after reset");

    send_req(build_req(0, cce_pkg::e_req_rd_shared, 16'h0040));
    end_test("read shared to empty block", 1);
    send_req(build_req(1, cce_pkg::e_req_rd_shared, 16'h0040));
    end_test("second shared reader", 2);

    // Three sharers built up before one exclusive reader
    send_req(build_req(0, cce_pkg::e_req_rd_shared, 16'h0480));
    send_req(build_req(1, cce_pkg::e_req_rd_shared, 16'h0480));
    send_req(build_req(2, cce_pkg::e_req_rd_shared, 16'h0480));
    send_req(build_req(3, cce_pkg::e_req_rd_excl, 16'h0480));
    end_test("exclusive over three sharers", 8);

    send_req(build_req(2, cce_pkg::e_req_rd_excl, 16'h08c0));
    send_req(build_req(2, cce_pkg::e_req_wb, 16'h08c0));
    send_req(build_req(3, cce_pkg::e_req_rd_shared, 16'h08c0));
    end_test("writeback then shared reader", 3);

    rand_ready   = 1'b1;
    stall_cycles = 0;
    for (int n = 0; n < NUM_RAND; n++) begin
      send_req(build_req($urandom_range(3), cce_pkg::lce_req_e'($urandom_range(2)),
                         rand_addr[$urandom_range(3)]));
      if ($urandom_range(3) == 0) begin
        @(posedge clk);
        #1;
      end
    end
    end_test("random requests with back-pressure", -1);
    rand_ready = 1'b0;
    check_value(stall_cycles != 0, 1'b1, "request stalls under back-pressure");
    check_value(done_total, accepted_total, "completed requests");

    errors += dut.cmd_checker.fail_count;
    $display("checks %0d, errors %0d, requests %0d", checks, errors, accepted_total);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim/cce_checker.sv
// Handshake assertions for the directory engine top level, attached to cce_top by bind
module cce_checker (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              req_valid_i,
  input logic              req_ready_i,
  input cce_pkg::lce_req_s req_i,
  input logic              cmd_valid_i,
  input logic              cmd_ready_i,
  input cce_pkg::lce_cmd_s cmd_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions that the testbench adds to its error total
  int fail_count = 0;

  // A stalled request keeps its payload and stays valid
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else begin
      fail_count++;
      $error("request dropped or changed while stalled");
    end

  // A stalled command keeps its payload and stays valid
  cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
    else begin
      fail_count++;
      $error("command dropped or changed while stalled");
    end

  cmd_reset: assert property (@(posedge clk_i) !rst_n_i |-> !cmd_valid_i)
    else begin
      fail_count++;
      $error("command valid high during reset");
    end

  cmd_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i |-> !$isunknown(cmd_i))
    else begin
      fail_count++;
      $error("command has unknown bits while valid");
    end

endmodule

//--- src/cce_top.sv
// Directory engine top level connecting the request buffer, engine, directory slices and issuer
module cce_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  cce_pkg::lce_req_s req_i,
  output logic              cmd_valid_o,
  input  logic              cmd_ready_i,
  output cce_pkg::lce_cmd_s cmd_o
);

  logic                       buf_valid;
  logic                       buf_ready;
  cce_pkg::lce_req_s          buf_req;
  logic [cce_pkg::ADDR_W-1:0] lookup_addr;
  logic                       issue_start;
  cce_pkg::lce_req_s          issue_req;
  logic                       issue_done;
  cce_pkg::coh_state_e        grant_state;
  cce_pkg::dir_update_s       dir_update;
  cce_pkg::holders_t          holders;

  cce_req_fifo req_buffer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_req_i    (req_i),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready),
    .out_req_o   (buf_req)
  );

  cce_engine engine (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (buf_valid),
    .req_ready_o   (buf_ready),
    .req_i         (buf_req),
    .lookup_addr_o (lookup_addr),
    .issue_start_o (issue_start),
    .issue_req_o   (issue_req),
    .issue_done_i  (issue_done),
    .grant_state_i (grant_state),
    .update_o      (dir_update)
  );

  // One slice per LCE, all looking up the same block
  for (genvar g = 0; g < cce_pkg::NUM_LCE; g++) begin : g_slice
    cce_dir_slice #(
      .LCE_IDX (g)
    ) dir_slice (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .lookup_addr_i (lookup_addr),
      .update_i      (dir_update),
      .state_o       (holders[g])
    );
  end

  cce_cmd_issue cmd_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (issue_start),
    .req_i         (issue_req),
    .holders_i     (holders),
    .cmd_valid_o   (cmd_valid_o),
    .cmd_ready_i   (cmd_ready_i),
    .cmd_o         (cmd_o),
    .done_o        (issue_done),
    .grant_state_o (grant_state)
  );

endmodule

//--- src/cce_cmd_issue.sv
// Command issuer that walks the holder states and sends invalidate, downgrade, grant or ack commands
module cce_cmd_issue (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  cce_pkg::lce_req_s   req_i,
  input  cce_pkg::holders_t   holders_i,
  output logic                cmd_valid_o,
  input  logic                cmd_ready_i,
  output cce_pkg::lce_cmd_s   cmd_o,
  output logic                done_o,
  output cce_pkg::coh_state_e grant_state_o
);

  typedef enum logic {
    e_idle,
    e_send
  } issue_state_e;

  issue_state_e                   state_q;
  cce_pkg::lce_req_s              req_q;
  cce_pkg::holders_t              holders_q;
  logic [cce_pkg::NUM_LCE-1:0]    sent_q;
  logic                           done_q;
  logic [cce_pkg::NUM_LCE-1:0]    need_cmd;
  logic [cce_pkg::NUM_LCE-1:0]    pend;
  logic                           others_held;
  logic                           pend_any;
  logic [cce_pkg::LCE_ID_W-1:0]   pend_idx;
  logic                           cmd_fire;

  // Which other LCEs need a command for this request
  always_comb begin
    need_cmd    = '0;
    others_held = 1'b0;
    for (int i = 0; i < cce_pkg::NUM_LCE; i++) begin
      if (i[cce_pkg::LCE_ID_W-1:0] != req_q.lce_id) begin
        if (holders_q[i] != cce_pkg::e_coh_i) begin
          others_held = 1'b1;
        end
        case (req_q.req_type)
          cce_pkg::e_req_rd_excl:   need_cmd[i] = (holders_q[i] != cce_pkg::e_coh_i);
          cce_pkg::e_req_rd_shared: need_cmd[i] = (holders_q[i] == cce_pkg::e_coh_e);
          default:                  need_cmd[i] = 1'b0;
        endcase
      end
    end
  end

  assign pend = need_cmd & ~sent_q;

  // Lowest pending index goes first
  always_comb begin
    pend_any = 1'b0;
    pend_idx = '0;
    for (int i = cce_pkg::NUM_LCE - 1; i >= 0; i--) begin
      if (pend[i]) begin
        pend_any = 1'b1;
        pend_idx = i[cce_pkg::LCE_ID_W-1:0];
      end
    end
  end

  always_comb begin
    case (req_q.req_type)
      cce_pkg::e_req_rd_excl:   grant_state_o = cce_pkg::e_coh_e;
      cce_pkg::e_req_rd_shared: grant_state_o = others_held ? cce_pkg::e_coh_s : cce_pkg::e_coh_e;
      default:                  grant_state_o = cce_pkg::e_coh_i;
    endcase
  end

  // Command depends only on held state, so it is stable while stalled
  always_comb begin
    cmd_o.addr   = req_q.addr;
    cmd_o.dst_id = pend_any ? pend_idx : req_q.lce_id;
    if (pend_any) begin
      cmd_o.opcode = (req_q.req_type == cce_pkg::e_req_rd_excl) ?
                     cce_pkg::e_cmd_inv : cce_pkg::e_cmd_downgrade;
    end else if (req_q.req_type == cce_pkg::e_req_wb) begin
      cmd_o.opcode = cce_pkg::e_cmd_wb_ack;
    end else if (grant_state_o == cce_pkg::e_coh_s) begin
      cmd_o.opcode = cce_pkg::e_cmd_grant_s;
    end else begin
      cmd_o.opcode = cce_pkg::e_cmd_grant_e;
    end
  end

  assign cmd_valid_o = (state_q == e_send);
  assign cmd_fire    = cmd_valid_o & cmd_ready_i;
  assign done_o      = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= e_idle;
      sent_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        state_q <= e_send;
        sent_q  <= '0;
      end else if (cmd_fire) begin
        if (pend_any) begin
          sent_q[pend_idx] <= 1'b1;
        end else begin
          // Grant or ack was the last command
          state_q <= e_idle;
          done_q  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      req_q     <= req_i;
      holders_q <= holders_i;
    end
  end

endmodule

//--- src/cce_engine.sv
// Request sequencer that serves one LCE request at a time through lookup, command issue and update
module cce_engine (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  cce_pkg::lce_req_s          req_i,
  output logic [cce_pkg::ADDR_W-1:0] lookup_addr_o,
  output logic                       issue_start_o,
  output cce_pkg::lce_req_s          issue_req_o,
  input  logic                       issue_done_i,
  input  cce_pkg::coh_state_e        grant_state_i,
  output cce_pkg::dir_update_s       update_o
);

  typedef enum logic [1:0] {
    e_idle,
    e_lookup,
    e_issue,
    e_update
  } eng_state_e;

  eng_state_e          state_q;
  eng_state_e          state_d;
  cce_pkg::lce_req_s   req_q;
  cce_pkg::coh_state_e grant_q;
  logic                req_fire;

  assign req_ready_o = (state_q == e_idle);
  assign req_fire    = req_valid_i & req_ready_o;

  // Slices see the held block address for the whole request
  assign lookup_addr_o = req_q.addr;
  assign issue_req_o   = req_q;

  // Holder states settle during the lookup cycle and are sampled with start
  assign issue_start_o = (state_q == e_lookup);

  assign update_o.valid       = (state_q == e_update);
  assign update_o.req         = req_q;
  assign update_o.grant_state = grant_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      e_idle: begin
        if (req_fire) begin
          state_d = e_lookup;
        end
      end
      e_lookup: state_d = e_issue;
      e_issue: begin
        if (issue_done_i) begin
          state_d = e_update;
        end
      end
      e_update: state_d = e_idle;
      default:  state_d = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= e_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= req_i;
    end
    // Granted state is only valid alongside done
    if ((state_q == e_issue) && issue_done_i) begin
      grant_q <= grant_state_i;
    end
  end

endmodule

//--- src/cce_dir_slice.sv
// Direct-mapped directory slice for one LCE, combinational lookup and per-slice state update
module cce_dir_slice #(
  parameter int LCE_IDX = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [cce_pkg::ADDR_W-1:0] lookup_addr_i,
  input  cce_pkg::dir_update_s       update_i,
  output cce_pkg::coh_state_e        state_o
);

  cce_pkg::dir_entry_s             entries_q [cce_pkg::NUM_SETS];
  logic [cce_pkg::SET_W-1:0]       lk_set;
  logic [cce_pkg::TAG_W-1:0]       lk_tag;
  cce_pkg::dir_entry_s             lk_entry;
  logic [cce_pkg::SET_W-1:0]       upd_set;
  logic [cce_pkg::TAG_W-1:0]       upd_tag;
  cce_pkg::dir_entry_s             upd_entry;
  cce_pkg::dir_entry_s             next_entry;
  logic                            is_requester;
  logic                            upd_hit;

  // Lookup side, a tag mismatch reads as invalid
  assign lk_set   = lookup_addr_i[cce_pkg::BLOCK_OFFSET_W +: cce_pkg::SET_W];
  assign lk_tag   = lookup_addr_i[cce_pkg::ADDR_W-1 -: cce_pkg::TAG_W];
  assign lk_entry = entries_q[lk_set];
  assign state_o  = (lk_entry.tag == lk_tag) ? lk_entry.state : cce_pkg::e_coh_i;

  assign upd_set      = update_i.req.addr[cce_pkg::BLOCK_OFFSET_W +: cce_pkg::SET_W];
  assign upd_tag      = update_i.req.addr[cce_pkg::ADDR_W-1 -: cce_pkg::TAG_W];
  assign upd_entry    = entries_q[upd_set];
  assign upd_hit      = (upd_entry.tag == upd_tag);
  assign is_requester = (int'(update_i.req.lce_id) == LCE_IDX);

  always_comb begin
    next_entry = upd_entry;
    if (is_requester) begin
      // Requester slot is overwritten, any older block was evicted by the LCE
      next_entry.tag   = upd_tag;
      next_entry.state = (update_i.req.req_type == cce_pkg::e_req_wb) ?
                         cce_pkg::e_coh_i : update_i.grant_state;
    end else if (upd_hit) begin
      case (update_i.req.req_type)
        cce_pkg::e_req_rd_excl: next_entry.state = cce_pkg::e_coh_i;
        cce_pkg::e_req_rd_shared: begin
          if (upd_entry.state == cce_pkg::e_coh_e) begin
            next_entry.state = cce_pkg::e_coh_s;
          end
        end
        default: next_entry = upd_entry;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < cce_pkg::NUM_SETS; i++) begin
        entries_q[i] <= '{tag: '0, state: cce_pkg::e_coh_i};
      end
    end else if (update_i.valid) begin
      entries_q[upd_set] <= next_entry;
    end
  end

endmodule

//--- src/cce_req_fifo.sv
// Two-entry request buffer between the LCE request port and the engine, valid/ready on both sides
module cce_req_fifo (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  cce_pkg::lce_req_s in_req_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output cce_pkg::lce_req_s out_req_o
);

  cce_pkg::lce_req_s mem_q [2];
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        count_q;
  logic              push;
  logic              pop;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_req_o   = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_req_i;
    end
  end

endmodule

//--- src/cce_pkg.sv
// Shared widths, coherence enums and message structs for the directory engine, used by scoped names
package cce_pkg;

  // Engine geometry
  localparam int NUM_LCE        = 4;
  localparam int LCE_ID_W       = 2;
  localparam int ADDR_W         = 16;
  localparam int BLOCK_OFFSET_W = 6;
  localparam int SET_W          = 4;
  localparam int NUM_SETS       = 16;
  localparam int TAG_W          = ADDR_W - SET_W - BLOCK_OFFSET_W;

  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2
  } coh_state_e;

  typedef enum logic [1:0] {
    e_req_rd_shared = 2'd0,
    e_req_rd_excl   = 2'd1,
    e_req_wb        = 2'd2
  } lce_req_e;

  typedef enum logic [2:0] {
    e_cmd_inv       = 3'd0,
    e_cmd_downgrade = 3'd1,
    e_cmd_grant_s   = 3'd2,
    e_cmd_grant_e   = 3'd3,
    e_cmd_wb_ack    = 3'd4
  } lce_cmd_e;

  // Request from an LCE
  typedef struct packed {
    logic [LCE_ID_W-1:0] lce_id;
    lce_req_e            req_type;
    logic [ADDR_W-1:0]   addr;
  } lce_req_s;

  // Command to an LCE
  typedef struct packed {
    logic [LCE_ID_W-1:0] dst_id;
    lce_cmd_e            opcode;
    logic [ADDR_W-1:0]   addr;
  } lce_cmd_s;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    coh_state_e       state;
  } dir_entry_s;

  // Broadcast to every slice once the commands of a request are out
  typedef struct packed {
    logic       valid;
    lce_req_s   req;
    coh_state_e grant_state;
  } dir_update_s;

  // One state per slice for the block under lookup
  typedef coh_state_e [NUM_LCE-1:0] holders_t;

endpackage
